/* spi_gpu_settings.svh */
`ifndef SPI_GPU_SETTINGS_SVH
`define SPI_GPU_SETTINGS_SVH

// value returned by the read magic number command
`define SPI_GPU_MAGIC 16'hA5C3

// turnaround cycles between command/read data and the response
`define SPI_GPU_DUMMY_CYCLES 2

// fixed upper bits of status register 0
`define SPI_GPU_STATUS_ID 5'b10110

// per-phase nibble counter width
// covers the longest audio write (2 + 256*8 nibbles)
`define SPI_GPU_CNT_W 12

// audio fifo fill level width
`define SPI_GPU_WNUM_W 11

`endif

/* spi_gpu_pkg.sv */
`default_nettype none

`include "spi_gpu_settings.svh"

package spi_gpu_pkg;

    // one qspi transfer on the four data lines
    typedef logic [3:0] nibble_t;

    // audio sample as written to the fifo
    typedef logic [31:0] sample_t;

    // response word, shifted out msb nibble first
    typedef logic [15:0] resp_t;

    typedef logic [`SPI_GPU_CNT_W-1:0] count_t;   // nibbles within a phase
    typedef logic [`SPI_GPU_WNUM_W-1:0] wnum_t;   // fifo fill level

    // transaction phases
    typedef enum logic [2:0]
    {
        IDLE        = 3'd0,   // first nibble of the command
        COMMAND     = 3'd1,   // second nibble of the command
        READ        = 3'd2,   // master to slave data
        WRITE_DUMMY = 3'd3,   // turnaround before the response
        WRITE       = 3'd4,   // slave to master data
        DONE        = 3'd5    // waits for cs to rise
    } phase_t;

    // bit 7 marks a read phase, bit 6 a write phase
    typedef enum logic [7:0]
    {
        CMD_DISABLE_OUTPUT     = 8'b0000_0000,
        CMD_ENABLE_OUTPUT      = 8'b0000_0001,
        CMD_READ_STATUS0       = 8'b0100_0000,
        CMD_AUDIO_READ_STATUS  = 8'b0101_0000,
        CMD_READ_MAGIC_NUMBER  = 8'b0110_0000,
        CMD_AUDIO_BUFFER_WRITE = 8'b1101_0001
    } cmd_t;

endpackage

`default_nettype wire

/* spi_phase_fsm.sv */
`default_nettype none

`include "spi_gpu_settings.svh"

module spi_phase_fsm
(
    input  logic                  sclk,
    input  logic                  reset,
    input  logic                  cs,
    input  logic                  has_read,
    input  logic                  has_write,
    input  logic                  read_done,
    input  logic                  write_done,
    input  spi_gpu_pkg::count_t   count,
    input  logic                  saturated,
    output spi_gpu_pkg::phase_t   phase,
    output logic                  phase_change
);
    spi_gpu_pkg::phase_t next_phase;

    // after the last dummy nibble the response starts
    wire dummy_over = count >= spi_gpu_pkg::count_t'(`SPI_GPU_DUMMY_CYCLES - 1);

    always_comb
    begin
        if (saturated)
            next_phase = spi_gpu_pkg::DONE;   // runaway transaction
        else
        begin
            case (phase)
                spi_gpu_pkg::IDLE:
                    next_phase = spi_gpu_pkg::COMMAND;
                spi_gpu_pkg::COMMAND:
                    if (has_read)
                        next_phase = spi_gpu_pkg::READ;
                    else if (has_write)
                        next_phase = spi_gpu_pkg::WRITE_DUMMY;
                    else
                        next_phase = spi_gpu_pkg::DONE;   // no data phase or undefined
                spi_gpu_pkg::READ:
                    if (!read_done)
                        next_phase = spi_gpu_pkg::READ;
                    else if (has_write)
                        next_phase = spi_gpu_pkg::WRITE_DUMMY;
                    else
                        next_phase = spi_gpu_pkg::DONE;
                spi_gpu_pkg::WRITE_DUMMY:
                    next_phase = dummy_over ? spi_gpu_pkg::WRITE : spi_gpu_pkg::WRITE_DUMMY;
                spi_gpu_pkg::WRITE:
                    next_phase = write_done ? spi_gpu_pkg::DONE : spi_gpu_pkg::WRITE;
                default:
                    next_phase = spi_gpu_pkg::DONE;   // DONE holds until cs rises
            endcase
        end
    end

    assign phase_change = next_phase != phase;

    always_ff @(posedge sclk)
    begin
        if (reset || cs)
            phase <= spi_gpu_pkg::IDLE;
        else
            phase <= next_phase;
    end

endmodule

`default_nettype wire

/* nibble_counter.sv */
`default_nettype none

module nibble_counter
(
    input  logic                  sclk,
    input  logic                  reset,
    input  logic                  cs,
    input  logic                  phase_change,
    output spi_gpu_pkg::count_t   count,
    output logic                  saturated
);
    // all ones is the ceiling, the fsm bails out to DONE there
    assign saturated = &count;

    always_ff @(posedge sclk)
    begin
        if (reset || cs)
            count <= '0;
        else if (phase_change)
            count <= '0;   // first nibble of the new phase is 0
        else if (!saturated)
            count <= count + 1'b1;
    end

endmodule

`default_nettype wire

/* command_decoder.sv */
`default_nettype none

module command_decoder
(
    input  logic                   sclk,
    input  logic                   reset,
    input  logic                   cs,
    input  spi_gpu_pkg::phase_t    phase,
    input  spi_gpu_pkg::nibble_t   data_in,
    output spi_gpu_pkg::cmd_t      cmd,
    output logic                   has_read,
    output logic                   has_write,
    output logic                   is_defined
);
    logic [7:0] cmd_q;

    always_ff @(posedge sclk)
    begin
        if (reset || cs)
            cmd_q <= '0;
        else if (phase == spi_gpu_pkg::IDLE || phase == spi_gpu_pkg::COMMAND)
            cmd_q <= {cmd_q[3:0], data_in};   // high nibble first
    end

    // low nibble is used live so the fsm can branch at the end of COMMAND
    assign cmd = (phase == spi_gpu_pkg::COMMAND) ? spi_gpu_pkg::cmd_t'({cmd_q[3:0], data_in})
                                                  : spi_gpu_pkg::cmd_t'(cmd_q);

    always_comb
    begin
        case (cmd)
            spi_gpu_pkg::CMD_DISABLE_OUTPUT,
            spi_gpu_pkg::CMD_ENABLE_OUTPUT,
            spi_gpu_pkg::CMD_READ_STATUS0,
            spi_gpu_pkg::CMD_AUDIO_READ_STATUS,
            spi_gpu_pkg::CMD_READ_MAGIC_NUMBER,
            spi_gpu_pkg::CMD_AUDIO_BUFFER_WRITE:
                is_defined = 1'b1;
            default:
                is_defined = 1'b0;
        endcase
    end

    assign has_read  = is_defined & cmd[7];
    assign has_write = is_defined & cmd[6];

endmodule

`default_nettype wire

/* audio_sample_loader.sv */
`default_nettype none

module audio_sample_loader
(
    input  logic                   sclk,
    input  logic                   reset,
    input  logic                   cs,
    input  spi_gpu_pkg::phase_t    phase,
    input  spi_gpu_pkg::cmd_t      cmd,
    input  spi_gpu_pkg::count_t    count,
    input  spi_gpu_pkg::nibble_t   data_in,
    input  logic                   fifo_full,
    input  logic                   fifo_almost_full,
    output logic                   read_done,
    output logic                   fifo_wren,
    output spi_gpu_pkg::sample_t   fifo_data,
    output logic                   full_seen,
    output logic                   almost_full_seen
);
    logic [7:0]           n_q;         // sample count, 0 means 256
    logic [8:0]           n_total;
    spi_gpu_pkg::count_t  last_cnt;    // count of the final data nibble
    spi_gpu_pkg::count_t  data_idx;    // nibble index within the sample data
    spi_gpu_pkg::sample_t sample_q;
    spi_gpu_pkg::sample_t word;

    wire active = phase == spi_gpu_pkg::READ && cmd == spi_gpu_pkg::CMD_AUDIO_BUFFER_WRITE;

    assign n_total  = (n_q == 8'd0) ? 9'd256 : {1'b0, n_q};
    assign last_cnt = spi_gpu_pkg::count_t'({n_total, 3'b000}) + 1'b1;
    assign data_idx = count - 2'd2;

    // sample as it arrives, first byte ends up in the top bits
    assign word = {sample_q[27:0], data_in};

    assign read_done = active && count == last_cnt;

    always_ff @(posedge sclk)
    begin
        if (reset || cs)
        begin
            n_q              <= '0;
            fifo_wren        <= 1'b0;
            full_seen        <= 1'b0;
            almost_full_seen <= 1'b0;
        end
        else
        begin
            fifo_wren <= 1'b0;
            if (active)
            begin
                if (count < 2)
                    n_q <= {n_q[3:0], data_in};
                else if (data_idx[2:0] == 3'b111)
                    fifo_wren <= 1'b1;   // eighth nibble of a sample
                if (fifo_full)
                    full_seen <= 1'b1;
                if (fifo_almost_full)
                    almost_full_seen <= 1'b1;
            end
        end
    end

    always_ff @(posedge sclk)
    begin
        if (active && count >= 2)
        begin
            sample_q <= word;
            if (data_idx[2:0] == 3'b111)
                fifo_data <= {word[7:0], word[15:8], word[23:16], word[31:24]};   // lsb byte came first
        end
    end

endmodule

`default_nettype wire

/* response_shifter.sv */
`default_nettype none

`include "spi_gpu_settings.svh"

module response_shifter
(
    input  logic                   sclk,
    input  logic                   reset,
    input  logic                   cs,
    input  spi_gpu_pkg::phase_t    phase,
    input  logic                   phase_change,
    input  spi_gpu_pkg::cmd_t      cmd,
    input  logic                   is_defined,
    input  spi_gpu_pkg::count_t    count,
    input  logic                   hblank,
    input  logic                   vblank,
    input  spi_gpu_pkg::wnum_t     fifo_wnum,
    input  logic                   fifo_full,
    input  logic                   fifo_almost_full,
    input  logic                   full_seen,
    input  logic                   almost_full_seen,
    output spi_gpu_pkg::nibble_t   data_out,
    output logic                   data_oe,
    output logic                   write_done,
    output logic                   output_enable
);
    logic [1:0]          hblank_ff;
    logic [1:0]          vblank_ff;
    logic [7:0]          status0;
    logic                cap_full;
    logic                cap_almost_full;
    spi_gpu_pkg::wnum_t  cap_wnum;
    spi_gpu_pkg::resp_t  resp_word;
    spi_gpu_pkg::resp_t  shift_q;
    spi_gpu_pkg::count_t last_nibble;

    wire enter_write = phase == spi_gpu_pkg::WRITE_DUMMY && phase_change;
    wire stay_write  = phase == spi_gpu_pkg::WRITE && !phase_change;

    // blanking comes from the video clock domain
    always_ff @(posedge sclk)
    begin
        hblank_ff <= {hblank_ff[0], hblank};
        vblank_ff <= {vblank_ff[0], vblank};
    end

    assign status0 = {`SPI_GPU_STATUS_ID, hblank_ff[1], vblank_ff[1], output_enable};

    always_ff @(posedge sclk)
    begin
        if (reset)
            output_enable <= 1'b0;
        else if (!cs && phase == spi_gpu_pkg::COMMAND && is_defined)
        begin
            if (cmd == spi_gpu_pkg::CMD_ENABLE_OUTPUT)
                output_enable <= 1'b1;
            else if (cmd == spi_gpu_pkg::CMD_DISABLE_OUTPUT)
                output_enable <= 1'b0;
        end
    end

    // fifo snapshot on the first dummy cycle
    always_ff @(posedge sclk)
    begin
        if (phase == spi_gpu_pkg::WRITE_DUMMY && count == '0)
        begin
            cap_full        <= fifo_full;
            cap_almost_full <= fifo_almost_full;
            cap_wnum        <= fifo_wnum;
        end
    end

    always_comb
    begin
        case (cmd)
            spi_gpu_pkg::CMD_READ_STATUS0:
                resp_word = {status0, 8'h00};
            spi_gpu_pkg::CMD_READ_MAGIC_NUMBER:
                resp_word = `SPI_GPU_MAGIC;
            spi_gpu_pkg::CMD_AUDIO_READ_STATUS:
                resp_word = {2'b00, cap_almost_full, cap_full, 1'b0, cap_wnum};
            spi_gpu_pkg::CMD_AUDIO_BUFFER_WRITE:
                resp_word = {almost_full_seen, full_seen, cap_almost_full, cap_full, 1'b0,
                             cap_wnum};
            default:
                resp_word = '0;
        endcase
    end

    // status0 is one byte, everything else two
    assign last_nibble = (cmd == spi_gpu_pkg::CMD_READ_STATUS0) ? spi_gpu_pkg::count_t'(1)
                                                                : spi_gpu_pkg::count_t'(3);
    assign write_done  = phase == spi_gpu_pkg::WRITE && count >= last_nibble;

    always_ff @(posedge sclk)
    begin
        if (reset || cs)
        begin
            data_out <= '0;
            data_oe  <= 1'b0;
        end
        else
        begin
            data_oe <= enter_write || stay_write;
            if (enter_write)
                data_out <= resp_word[15:12];   // first nibble goes out with the phase switch
            else if (phase == spi_gpu_pkg::WRITE)
                data_out <= shift_q[15:12];
        end
    end

    always_ff @(posedge sclk)
    begin
        if (enter_write)
            shift_q <= {resp_word[11:0], 4'h0};
        else if (phase == spi_gpu_pkg::WRITE)
            shift_q <= {shift_q[11:0], 4'h0};
    end

endmodule

`default_nettype wire

/* spi_gpu_top.sv */
`default_nettype none

module spi_gpu_top
(
    input  logic                   sclk,
    input  logic                   reset,
    input  logic                   cs,
    input  spi_gpu_pkg::nibble_t   data_in,
    output spi_gpu_pkg::nibble_t   data_out,
    output logic                   data_oe,
    input  logic                   hblank,
    input  logic                   vblank,
    output logic                   output_enable,
    output logic                   fifo_wren,
    output spi_gpu_pkg::sample_t   fifo_data,
    input  spi_gpu_pkg::wnum_t     fifo_wnum,
    input  logic                   fifo_full,
    input  logic                   fifo_almost_full
);
    spi_gpu_pkg::phase_t phase;
    logic                phase_change;
    spi_gpu_pkg::count_t count;
    logic                saturated;
    spi_gpu_pkg::cmd_t   cmd;
    logic                has_read;
    logic                has_write;
    logic                is_defined;
    logic                read_done;
    logic                write_done;
    logic                full_seen;
    logic                almost_full_seen;

    spi_phase_fsm fsm0 (
        .sclk         (sclk),
        .reset        (reset),
        .cs           (cs),
        .has_read     (has_read),
        .has_write    (has_write),
        .read_done    (read_done),
        .write_done   (write_done),
        .count        (count),
        .saturated    (saturated),
        .phase        (phase),
        .phase_change (phase_change)
    );

    nibble_counter cnt0 (
        .sclk         (sclk),
        .reset        (reset),
        .cs           (cs),
        .phase_change (phase_change),
        .count        (count),
        .saturated    (saturated)
    );

    command_decoder dec0 (
        .sclk       (sclk),
        .reset      (reset),
        .cs         (cs),
        .phase      (phase),
        .data_in    (data_in),
        .cmd        (cmd),
        .has_read   (has_read),
        .has_write  (has_write),
        .is_defined (is_defined)
    );

    audio_sample_loader aud0 (
        .sclk             (sclk),
        .reset            (reset),
        .cs               (cs),
        .phase            (phase),
        .cmd              (cmd),
        .count            (count),
        .data_in          (data_in),
        .fifo_full        (fifo_full),
        .fifo_almost_full (fifo_almost_full),
        .read_done        (read_done),
        .fifo_wren        (fifo_wren),
        .fifo_data        (fifo_data),
        .full_seen        (full_seen),
        .almost_full_seen (almost_full_seen)
    );

    response_shifter rsp0 (
        .sclk             (sclk),
        .reset            (reset),
        .cs               (cs),
        .phase            (phase),
        .phase_change     (phase_change),
        .cmd              (cmd),
        .is_defined       (is_defined),
        .count            (count),
        .hblank           (hblank),
        .vblank           (vblank),
        .fifo_wnum        (fifo_wnum),
        .fifo_full        (fifo_full),
        .fifo_almost_full (fifo_almost_full),
        .full_seen        (full_seen),
        .almost_full_seen (almost_full_seen),
        .data_out         (data_out),
        .data_oe          (data_oe),
        .write_done       (write_done),
        .output_enable    (output_enable)
    );

endmodule

`default_nettype wire

/* spi_gpu_sva.sv */
`default_nettype none

module spi_gpu_sva
(
    input logic                sclk,
    input logic                reset,
    input logic                cs,
    input spi_gpu_pkg::phase_t phase,
    input logic                data_oe,
    input logic                fifo_wren
);
    int assert_failures = 0;   // read by the testbench at the end of the run

    // the bus is driven only while the response shifts out
    oe_in_write: assert property (@(posedge sclk) disable iff (reset)
        data_oe |-> phase == spi_gpu_pkg::WRITE)
        else
        begin
            assert_failures++;
            $error("data_oe high outside WRITE");
        end

    wren_single: assert property (@(posedge sclk) disable iff (reset)
        fifo_wren |=> !fifo_wren)   // one pulse per sample
        else
        begin
            assert_failures++;
            $error("fifo_wren high for two cycles");
        end

    quiet_when_deselected: assert property (@(posedge sclk) disable iff (reset)
        cs && $past(cs) |-> !data_oe && !fifo_wren)
        else
        begin
            assert_failures++;
            $error("data_oe or fifo_wren active with cs high");
        end

endmodule

bind spi_gpu_top spi_gpu_sva sva0
(
    .sclk      (sclk),
    .reset     (reset),
    .cs        (cs),
    .phase     (phase),
    .data_oe   (data_oe),
    .fifo_wren (fifo_wren)
);

`default_nettype wire

/* tb_spi_gpu.sv */
`default_nettype none

module tb_spi_gpu;
    // reset plus 9 transactions of up to 16 cycles and 8 extra cycles per audio sample
    localparam int TEST_CYCLES = 10 + 9 * 16 + 8 * 10;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic                 sclk = 1'b0;
    logic                 reset;
    logic                 cs;
    spi_gpu_pkg::nibble_t data_in;
    spi_gpu_pkg::nibble_t data_out;
    logic                 data_oe;
    logic                 hblank;
    logic                 vblank;
    logic                 output_enable;
    logic                 fifo_wren;
    spi_gpu_pkg::sample_t fifo_data;
    spi_gpu_pkg::wnum_t   fifo_wnum;
    logic                 fifo_full;
    logic                 fifo_almost_full;

    int                   errors = 0;
    int                   cycles = 0;
    int                   fifo_level = 0;
    int                   wren_count = 0;
    logic [31:0]          lfsr = 32'hd4ac;
    logic [31:0]          expected_q[$];   // samples sent but not yet written to the fifo
    logic                 oe_exp = 1'b0;
    logic                 af_seen;
    logic                 f_seen;
    logic                 snap_af;
    logic                 snap_f;
    spi_gpu_pkg::wnum_t   snap_wnum;

    spi_gpu_top dut0 (.*);

    always #10 sclk = ~sclk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    task automatic draw_sample(output logic [31:0] s);
        int i;
        s = '0;
        for (i = 0; i < 32; i++)
        begin
            lfsr = lfsr_next(lfsr);
            s    = {s[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [15:0] expected_response(input logic [7:0] cmd, input logic oe,
        input logic hb, input logic vb, input logic af_s, input logic f_s, input logic af,
        input logic f, input spi_gpu_pkg::wnum_t wnum);
        case (cmd)
            spi_gpu_pkg::CMD_READ_STATUS0:       return {5'b10110, hb, vb, oe, 8'h00};
            spi_gpu_pkg::CMD_READ_MAGIC_NUMBER:  return 16'hA5C3;
            spi_gpu_pkg::CMD_AUDIO_READ_STATUS:  return {2'b00, af, f, 1'b0, wnum};
            spi_gpu_pkg::CMD_AUDIO_BUFFER_WRITE: return {af_s, f_s, af, f, 1'b0, wnum};
            default:                             return 16'h0000;
        endcase
    endfunction

    // fifo model that also compares every written sample
    always @(posedge sclk)
    begin
        if (fifo_wren)
        begin
            wren_count++;
            if (expected_q.size() == 0)
            begin
                errors++;
                $display("fifo write seen with no sample sent");
            end
            else
                check("fifo_data", fifo_data, expected_q.pop_front());
            if (fifo_level < 8)
                fifo_level++;   // full fifo drops the write
            fifo_wnum        <= spi_gpu_pkg::wnum_t'(fifo_level);
            fifo_almost_full <= fifo_level >= 6;
            fifo_full        <= fifo_level >= 8;
        end
    end

    always @(posedge sclk)
    begin
        cycles++;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("run stopped, transactions not finished after %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d", errors);
            $display("Checks failed");
            $finish;
        end
    end

    // ends on the edge of cycle 1
    task automatic start_cmd(input logic [7:0] cmd);
        af_seen = 1'b0;
        f_seen  = 1'b0;
        @(posedge sclk);
        cs      <= 1'b0;
        data_in <= cmd[7:4];
        @(posedge sclk);
        data_in <= cmd[3:0];
        @(posedge sclk);
    endtask

    task automatic send_nibble(input spi_gpu_pkg::nibble_t n);
        data_in <= n;
        @(posedge sclk);
        af_seen = af_seen | fifo_almost_full;   // every data nibble edge is a READ cycle
        f_seen  = f_seen | fifo_full;
    endtask

    // fifo state as seen on the first dummy cycle
    task automatic take_snapshot();
        data_in <= '0;
        @(posedge sclk);
        snap_af   = fifo_almost_full;
        snap_f    = fifo_full;
        snap_wnum = fifo_wnum;
    endtask

    task automatic collect_response(input int n, output logic [15:0] word);
        int i;
        word = '0;
        @(posedge sclk);
        check("data_oe", data_oe, 1'b0);   // second dummy cycle
        @(posedge sclk);
        for (i = 0; i < n; i++)
        begin
            check("data_oe", data_oe, 1'b1);
            word = {word[11:0], data_out};
            @(posedge sclk);
        end
        check("data_oe", data_oe, 1'b0);
    endtask

    task automatic end_cmd();
        data_in <= '0;
        cs      <= 1'b1;
        repeat (3) @(posedge sclk);
    endtask

    task automatic read_cmd(input logic [7:0] cmd, input int n);
        logic [15:0] resp;
        logic [15:0] exp;
        start_cmd(cmd);
        take_snapshot();
        collect_response(n, resp);
        end_cmd();
        exp = expected_response(cmd, oe_exp, hblank, vblank, 1'b0, 1'b0, snap_af, snap_f,
                                snap_wnum);
        if (n == 2)
            check("data_out", resp[7:0], exp[15:8]);   // status0 is a single byte
        else
            check("data_out", resp, exp);
    endtask

    task automatic set_output(input logic enable);
        start_cmd(enable ? spi_gpu_pkg::CMD_ENABLE_OUTPUT : spi_gpu_pkg::CMD_DISABLE_OUTPUT);
        end_cmd();
        oe_exp = enable;
        check("output_enable", output_enable, oe_exp);
    endtask

    task automatic undefined_cmd(input logic [7:0] cmd);
        int i;
        start_cmd(cmd);
        for (i = 0; i < 6; i++)
        begin
            data_in <= '0;
            @(posedge sclk);
            check("data_oe", data_oe, 1'b0);
            check("fifo_wren", fifo_wren, 1'b0);
        end
        end_cmd();
        check("output_enable", output_enable, oe_exp);
    endtask

    task automatic audio_write(input logic [7:0] n);
        logic [31:0] s;
        logic [15:0] resp;
        int          k;
        int          b;
        int          wren_before;
        wren_before = wren_count;
        start_cmd(spi_gpu_pkg::CMD_AUDIO_BUFFER_WRITE);
        send_nibble(n[7:4]);
        send_nibble(n[3:0]);
        for (k = 0; k < n; k++)
        begin
            draw_sample(s);
            expected_q.push_back(s);
            for (b = 0; b < 4; b++)
            begin
                send_nibble(s[8 * b + 4 +: 4]);   // lsb byte first, high nibble first
                send_nibble(s[8 * b +: 4]);
            end
        end
        take_snapshot();
        collect_response(4, resp);
        end_cmd();
        check("data_out", resp, expected_response(spi_gpu_pkg::CMD_AUDIO_BUFFER_WRITE, oe_exp,
              hblank, vblank, af_seen, f_seen, snap_af, snap_f, snap_wnum));
        check("fifo_wren pulses", wren_count - wren_before, n);
    endtask

    initial
    begin
        reset            = 1'b1;
        cs               = 1'b1;
        data_in          = '0;
        hblank           = 1'b1;
        vblank           = 1'b0;
        fifo_wnum        = '0;
        fifo_full        = 1'b0;
        fifo_almost_full = 1'b0;
        repeat (10) @(posedge sclk);
        reset <= 1'b0;
        repeat (2) @(posedge sclk);

        read_cmd(spi_gpu_pkg::CMD_READ_MAGIC_NUMBER, 4);
        set_output(1'b1);
        read_cmd(spi_gpu_pkg::CMD_READ_STATUS0, 2);
        hblank <= 1'b0;
        vblank <= 1'b1;
        set_output(1'b0);
        read_cmd(spi_gpu_pkg::CMD_READ_STATUS0, 2);
        undefined_cmd(8'h41);   // low nibble matches enable while output is off
        audio_write(8'd3);
        audio_write(8'd7);   // runs the fifo model past full
        read_cmd(spi_gpu_pkg::CMD_AUDIO_READ_STATUS, 4);

        if (expected_q.size() != 0)
        begin
            errors++;
            $display("%0d samples never reached the fifo", expected_q.size());
        end
        errors += dut0.sva0.assert_failures;
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
spi_gpu_pkg.sv
spi_phase_fsm.sv
nibble_counter.sv
command_decoder.sv
audio_sample_loader.sv
response_shifter.sv
spi_gpu_top.sv
spi_gpu_sva.sv
tb_spi_gpu.sv
